// ==== logic/la_core_pkg.sv ====
`default_nettype none

package la_core_pkg;

    typedef enum logic [2:0] {
        fetch_s,
        decode_s,
        execute_s,
        memory_s,
        writeback_s
    } cpu_state_t;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_slt,
        op_sltu,
        op_and,
        op_nor,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_sra,
        op_lui
    } alu_op_t;

    typedef enum logic [2:0] {
        br_none,
        br_b,
        br_bl,
        br_beq,
        br_bne,
        br_jirl
    } branch_kind_t;

    localparam logic [31:0] reset_pc = 32'h1c00_0000;

    // Major opcode, bits 31:26.
    localparam logic [5:0] op6_arith   = 6'h00;   // 3R ops, shifts and addi.w.
    localparam logic [5:0] op6_lu12i_w = 6'h05;
    localparam logic [5:0] op6_mem     = 6'h0a;   // ld.w and st.w.
    localparam logic [5:0] op6_jirl    = 6'h13;
    localparam logic [5:0] op6_b       = 6'h14;
    localparam logic [5:0] op6_bl      = 6'h15;
    localparam logic [5:0] op6_beq     = 6'h16;
    localparam logic [5:0] op6_bne     = 6'h17;

    // Bits 25:22.
    localparam logic [3:0] op4_3r      = 4'h0;
    localparam logic [3:0] op4_shift   = 4'h1;
    localparam logic [3:0] op4_ld_w    = 4'h2;
    localparam logic [3:0] op4_st_w    = 4'h6;
    localparam logic [3:0] op4_addi_w  = 4'ha;

    // Bits 21:20.
    localparam logic [1:0] op2_3r      = 2'h1;
    localparam logic [1:0] op2_shift   = 2'h0;

    // Bits 19:15 select the operation inside the 3R and shift groups.
    localparam logic [4:0] op5_add_w   = 5'h00;
    localparam logic [4:0] op5_sub_w   = 5'h02;
    localparam logic [4:0] op5_slt     = 5'h04;
    localparam logic [4:0] op5_sltu    = 5'h05;
    localparam logic [4:0] op5_nor     = 5'h08;
    localparam logic [4:0] op5_and     = 5'h09;
    localparam logic [4:0] op5_or      = 5'h0a;
    localparam logic [4:0] op5_xor     = 5'h0b;
    localparam logic [4:0] op5_slli_w  = 5'h01;
    localparam logic [4:0] op5_srli_w  = 5'h09;
    localparam logic [4:0] op5_srai_w  = 5'h11;

endpackage

`default_nettype wire

// ==== logic/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  wire [31:0]               inst,
    output la_core_pkg::alu_op_t      alu_op,
    output la_core_pkg::branch_kind_t branch_kind,
    output logic                     src1_is_pc,
    output logic                     src2_is_imm,
    output logic                     read_rd,
    output logic                     gr_we,
    output logic                     mem_we,
    output logic                     res_from_mem,
    output logic [4:0]               dest,
    output logic [31:0]              imm,
    output logic [31:0]              br_offs
);
    import la_core_pkg::*;

    logic [63:0] op_31_26_d;
    logic [15:0] op_25_22_d;
    logic [3:0]  op_21_20_d;
    logic [31:0] op_19_15_d;
    logic        grp_3r;
    logic        grp_shift;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic        inst_nor, inst_and, inst_or, inst_xor;
    logic        inst_slli_w, inst_srli_w, inst_srai_w;
    logic        inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic        inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    // One-hot decode of each opcode field.
    assign op_31_26_d = 64'd1 << inst[31:26];
    assign op_25_22_d = 16'd1 << inst[25:22];
    assign op_21_20_d = 4'd1 << inst[21:20];
    assign op_19_15_d = 32'd1 << inst[19:15];

    assign grp_3r    = op_31_26_d[op6_arith] & op_25_22_d[op4_3r] & op_21_20_d[op2_3r];
    assign grp_shift = op_31_26_d[op6_arith] & op_25_22_d[op4_shift] & op_21_20_d[op2_shift];

    assign inst_add_w   = grp_3r & op_19_15_d[op5_add_w];
    assign inst_sub_w   = grp_3r & op_19_15_d[op5_sub_w];
    assign inst_slt     = grp_3r & op_19_15_d[op5_slt];
    assign inst_sltu    = grp_3r & op_19_15_d[op5_sltu];
    assign inst_nor     = grp_3r & op_19_15_d[op5_nor];
    assign inst_and     = grp_3r & op_19_15_d[op5_and];
    assign inst_or      = grp_3r & op_19_15_d[op5_or];
    assign inst_xor     = grp_3r & op_19_15_d[op5_xor];
    assign inst_slli_w  = grp_shift & op_19_15_d[op5_slli_w];
    assign inst_srli_w  = grp_shift & op_19_15_d[op5_srli_w];
    assign inst_srai_w  = grp_shift & op_19_15_d[op5_srai_w];
    assign inst_addi_w  = op_31_26_d[op6_arith] & op_25_22_d[op4_addi_w];
    assign inst_lu12i_w = op_31_26_d[op6_lu12i_w] & ~inst[25];
    assign inst_ld_w    = op_31_26_d[op6_mem] & op_25_22_d[op4_ld_w];
    assign inst_st_w    = op_31_26_d[op6_mem] & op_25_22_d[op4_st_w];
    assign inst_jirl    = op_31_26_d[op6_jirl];
    assign inst_b       = op_31_26_d[op6_b];
    assign inst_bl      = op_31_26_d[op6_bl];
    assign inst_beq     = op_31_26_d[op6_beq];
    assign inst_bne     = op_31_26_d[op6_bne];

    always_comb begin
        if (inst_sub_w)                             alu_op = op_sub;
        else if (inst_slt)                          alu_op = op_slt;
        else if (inst_sltu)                         alu_op = op_sltu;
        else if (inst_and)                          alu_op = op_and;
        else if (inst_nor)                          alu_op = op_nor;
        else if (inst_or)                           alu_op = op_or;
        else if (inst_xor)                          alu_op = op_xor;
        else if (inst_slli_w)                       alu_op = op_sll;
        else if (inst_srli_w)                       alu_op = op_srl;
        else if (inst_srai_w)                       alu_op = op_sra;
        else if (inst_lu12i_w)                      alu_op = op_lui;
        else                                        alu_op = op_add;   // Also address and link.
    end

    always_comb begin
        if (inst_b)         branch_kind = br_b;
        else if (inst_bl)   branch_kind = br_bl;
        else if (inst_beq)  branch_kind = br_beq;
        else if (inst_bne)  branch_kind = br_bne;
        else if (inst_jirl) branch_kind = br_jirl;
        else                branch_kind = br_none;
    end

    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    assign i20 = inst[24:5];
    assign i26 = {inst[9:0], inst[25:10]};

    // Links use PC plus 4, shift amounts are zero extended.
    always_comb begin
        if (inst_jirl | inst_bl)
            imm = 32'd4;
        else if (inst_lu12i_w)
            imm = {i20, 12'b0};
        else if (grp_shift)
            imm = {27'b0, i12[4:0]};
        else
            imm = {{20{i12[11]}}, i12};
    end

    assign br_offs = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0} :
                                          {{14{i16[15]}}, i16, 2'b0};

    assign src1_is_pc   = inst_jirl | inst_bl;
    assign src2_is_imm  = grp_shift | inst_addi_w | inst_lu12i_w | inst_ld_w | inst_st_w
                        | inst_jirl | inst_bl;
    assign read_rd      = inst_beq | inst_bne | inst_st_w;   // Second operand comes from rd.
    assign gr_we        = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                        | inst_or | inst_xor | inst_slli_w | inst_srli_w | inst_srai_w
                        | inst_addi_w | inst_lu12i_w | inst_ld_w | inst_jirl | inst_bl;
    assign mem_we       = inst_st_w;
    assign res_from_mem = inst_ld_w;
    assign dest         = inst_bl ? 5'd1 : inst[4:0];

endmodule

`default_nettype wire

// ==== logic/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire         clk,
    input  wire  [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  wire  [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  wire         we,
    input  wire  [4:0]  waddr,
    input  wire  [31:0] wdata
);

    logic [31:0] rf [32];

    always_ff @(posedge clk) begin
        if (we)
            rf[waddr] <= wdata;   // r0 may be written, reads mask it.
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'b0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'b0 : rf[raddr2];

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire la_core_pkg::alu_op_t alu_op,
    input  wire [31:0]               alu_src1,
    input  wire [31:0]               alu_src2,
    output logic [31:0]              alu_result
);
    import la_core_pkg::*;

    logic [4:0]  shamt;
    logic [31:0] sum;
    logic [31:0] diff;

    assign shamt = alu_src2[4:0];
    assign sum   = alu_src1 + alu_src2;
    assign diff  = alu_src1 - alu_src2;

    always_comb begin
        case (alu_op)
            op_add:  alu_result = sum;
            op_sub:  alu_result = diff;
            op_slt:  alu_result = {31'b0, $signed(alu_src1) < $signed(alu_src2)};
            op_sltu: alu_result = {31'b0, alu_src1 < alu_src2};
            op_and:  alu_result = alu_src1 & alu_src2;
            op_nor:  alu_result = ~(alu_src1 | alu_src2);
            op_or:   alu_result = alu_src1 | alu_src2;
            op_xor:  alu_result = alu_src1 ^ alu_src2;
            op_sll:  alu_result = alu_src1 << shamt;
            op_srl:  alu_result = alu_src1 >> shamt;
            op_sra:  alu_result = $unsigned($signed(alu_src1) >>> shamt);
            op_lui:  alu_result = alu_src2;   // Immediate is already shifted up.
            default: alu_result = sum;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/mycpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mycpu_top (
    input  wire         clk,
    input  wire         reset,
    output logic        inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  wire  [31:0] inst_sram_rdata,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  wire  [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import la_core_pkg::*;

    cpu_state_t   state;
    cpu_state_t   state_next;
    logic [31:0]  pc;
    logic [31:0]  old_pc;
    logic [31:0]  inst_reg;
    logic [31:0]  inst_word;
    logic [31:0]  rj_reg;
    logic [31:0]  rkd_reg;
    logic [31:0]  alu_res_reg;
    alu_op_t      alu_op;
    branch_kind_t branch_kind;
    logic         src1_is_pc;
    logic         src2_is_imm;
    logic         read_rd;
    logic         gr_we;
    logic         mem_we;
    logic         res_from_mem;
    logic [4:0]   dest;
    logic [31:0]  imm;
    logic [31:0]  br_offs;
    logic [31:0]  rf_rdata1;
    logic [31:0]  rf_rdata2;
    logic         rf_we;
    logic [31:0]  rf_wdata;
    logic [31:0]  alu_src1;
    logic [31:0]  alu_src2;
    logic [31:0]  alu_result;
    logic         br_taken;
    logic [31:0]  br_target;

    // The word arrives from the SRAM during decode and is held afterwards.
    assign inst_word = (state == decode_s) ? inst_sram_rdata : inst_reg;

    inst_decoder u_decoder (
        .inst         (inst_word),
        .alu_op       (alu_op),
        .branch_kind  (branch_kind),
        .src1_is_pc   (src1_is_pc),
        .src2_is_imm  (src2_is_imm),
        .read_rd      (read_rd),
        .gr_we        (gr_we),
        .mem_we       (mem_we),
        .res_from_mem (res_from_mem),
        .dest         (dest),
        .imm          (imm),
        .br_offs      (br_offs)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (inst_word[9:5]),
        .rdata1 (rf_rdata1),
        .raddr2 (read_rd ? inst_word[4:0] : inst_word[14:10]),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (dest),
        .wdata  (rf_wdata)
    );

    assign alu_src1 = src1_is_pc ? pc : rj_reg;
    assign alu_src2 = src2_is_imm ? imm : rkd_reg;

    alu u_alu (
        .alu_op     (alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    always_comb begin
        case (branch_kind)
            br_b, br_bl, br_jirl: br_taken = 1'b1;
            br_beq:               br_taken = (rj_reg == rkd_reg);
            br_bne:               br_taken = (rj_reg != rkd_reg);
            default:              br_taken = 1'b0;
        endcase
    end

    assign br_target = (branch_kind == br_jirl) ? rj_reg + br_offs : pc + br_offs;

    always_comb begin
        case (state)
            fetch_s:   state_next = decode_s;
            decode_s:  state_next = execute_s;
            execute_s: begin
                if (mem_we | res_from_mem)
                    state_next = memory_s;
                else if (gr_we)
                    state_next = writeback_s;
                else
                    state_next = fetch_s;   // Branches without link and unknown words.
            end
            memory_s:  state_next = res_from_mem ? writeback_s : fetch_s;
            default:   state_next = fetch_s;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetch_s;
            pc    <= reset_pc;
        end else begin
            state <= state_next;
            if (state == execute_s)
                pc <= br_taken ? br_target : pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (state == decode_s) begin
            inst_reg <= inst_sram_rdata;
            rj_reg   <= rf_rdata1;
            rkd_reg  <= rf_rdata2;
        end
        if (state == execute_s) begin
            alu_res_reg <= alu_result;
            old_pc      <= pc;   // The PC moves on here, the trace needs the old one.
        end
    end

    assign inst_sram_we    = 1'b0;
    assign inst_sram_addr  = pc;
    assign inst_sram_wdata = 32'b0;

    assign data_sram_we    = (state == memory_s) & mem_we;
    assign data_sram_addr  = alu_res_reg;
    assign data_sram_wdata = rkd_reg;

    // Load data comes back one cycle after memory_s.
    assign rf_wdata = res_from_mem ? data_sram_rdata : alu_res_reg;
    assign rf_we    = (state == writeback_s) & gr_we;

    assign debug_wb_pc       = old_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

`default_nettype wire

// ==== verification/trace_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module trace_checker (
    input  wire         clk,
    input  wire         reset,
    input  wire         inst_sram_we,
    input  wire  [31:0] debug_wb_pc,
    input  wire  [3:0]  debug_wb_rf_we,
    input  wire  [4:0]  debug_wb_rf_wnum,
    input  wire  [31:0] debug_wb_rf_wdata,
    output logic        done,
    output int          checked,
    output int          error_count
);
    import la_core_pkg::*;

    logic [31:0] prog [1024];   // Filled by tb_top at time zero.
    logic [31:0] ref_regs [32];
    logic [31:0] ref_mem [256];
    logic [31:0] exp_pc [4096];
    logic [4:0]  exp_num [4096];
    logic [31:0] exp_data [4096];

    // Executes the program on its own state and lists every register write.
    function automatic int run_reference();
        logic [31:0] pc, w, a, res, next_pc, addr, offs16;
        logic [4:0]  rd;
        logic        wr;
        int          n;
        n = 0;
        pc = reset_pc;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = 32'b0;
        for (int i = 0; i < 256; i++)
            ref_mem[i] = 32'b0;
        for (int steps = 0; steps < 4000; steps++) begin
            w = prog[pc[11:2]];
            if (w == {op6_b, 26'b0})
                break;
            rd      = w[4:0];
            a       = ref_regs[w[9:5]];
            wr      = 1'b0;
            res     = 32'b0;
            next_pc = pc + 32'd4;
            offs16  = {{14{w[25]}}, w[25:10], 2'b0};
            addr    = a + {{20{w[21]}}, w[21:10]};
            case (w[31:26])
                op6_arith: begin
                    if (w[25:22] == op4_3r && w[21:20] == op2_3r) begin
                        wr = 1'b1;
                        case (w[19:15])
                            op5_add_w: res = a + ref_regs[w[14:10]];
                            op5_sub_w: res = a - ref_regs[w[14:10]];
                            op5_slt:   res = {31'b0, $signed(a) < $signed(ref_regs[w[14:10]])};
                            op5_sltu:  res = {31'b0, a < ref_regs[w[14:10]]};
                            op5_nor:   res = ~(a | ref_regs[w[14:10]]);
                            op5_and:   res = a & ref_regs[w[14:10]];
                            op5_or:    res = a | ref_regs[w[14:10]];
                            op5_xor:   res = a ^ ref_regs[w[14:10]];
                            default:   wr = 1'b0;
                        endcase
                    end else if (w[25:22] == op4_shift && w[21:20] == op2_shift) begin
                        wr = 1'b1;
                        case (w[19:15])
                            op5_slli_w: res = a << w[14:10];
                            op5_srli_w: res = a >> w[14:10];
                            op5_srai_w: res = $unsigned($signed(a) >>> w[14:10]);
                            default:    wr = 1'b0;
                        endcase
                    end else if (w[25:22] == op4_addi_w) begin
                        wr  = 1'b1;
                        res = addr;
                    end
                end
                op6_lu12i_w: begin
                    wr  = !w[25];
                    res = {w[24:5], 12'b0};
                end
                op6_mem: begin
                    if (w[25:22] == op4_ld_w) begin
                        wr  = 1'b1;
                        res = ref_mem[addr[9:2]];
                    end else if (w[25:22] == op4_st_w) begin
                        ref_mem[addr[9:2]] = ref_regs[rd];
                    end
                end
                op6_jirl: begin
                    wr      = 1'b1;
                    res     = pc + 32'd4;
                    next_pc = a + offs16;
                end
                op6_b:  next_pc = pc + {{4{w[9]}}, w[9:0], w[25:10], 2'b0};
                op6_bl: begin
                    wr      = 1'b1;
                    rd      = 5'd1;
                    res     = pc + 32'd4;
                    next_pc = pc + {{4{w[9]}}, w[9:0], w[25:10], 2'b0};
                end
                op6_beq: if (a == ref_regs[rd]) next_pc = pc + offs16;
                op6_bne: if (a != ref_regs[rd]) next_pc = pc + offs16;
                default: wr = 1'b0;
            endcase
            if (wr) begin
                exp_pc[n]   = pc;
                exp_num[n]  = rd;
                exp_data[n] = res;
                n = n + 1;
                if (rd != 5'd0)
                    ref_regs[rd] = res;   // r0 stays zero.
            end
            pc = next_pc;
        end
        return n;
    endfunction

    initial begin
        int exp_count;
        int wait_cycles;
        logic timed_out;
        done        = 1'b0;
        checked     = 0;
        error_count = 0;
        timed_out   = 1'b0;
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
            if (debug_wb_rf_we != 4'h0) begin
                $display("Register write traced while reset is asserted");
                error_count++;
            end
            if (inst_sram_we) begin
                $display("Instruction SRAM write enable went high");
                error_count++;
            end
        end while (reset && wait_cycles < 100);
        if (reset) begin
            $display("Reset never deasserted");
            error_count++;
            timed_out = 1'b1;
        end
        exp_count = run_reference();
        for (int i = 0; i < exp_count && !timed_out; i++) begin
            wait_cycles = 0;
            do begin
                @(negedge clk);
                wait_cycles++;
                if (inst_sram_we) begin
                    $display("Instruction SRAM write enable went high");
                    error_count++;
                end
            end while (debug_wb_rf_we == 4'h0 && wait_cycles < 2000);
            if (debug_wb_rf_we == 4'h0) begin
                $display("No register write seen for trace entry %0d", i);
                error_count++;
                timed_out = 1'b1;
            end else begin
                if (debug_wb_rf_we != 4'hf) begin
                    $display("Fail debug_wb_rf_we: got %h expected f", debug_wb_rf_we);
                    error_count++;
                end
                if (debug_wb_pc != exp_pc[i]) begin
                    $display("Fail debug_wb_pc: got %h expected %h", debug_wb_pc, exp_pc[i]);
                    error_count++;
                end
                if (debug_wb_rf_wnum != exp_num[i]) begin
                    $display("Fail debug_wb_rf_wnum: got %h expected %h at pc %h",
                             debug_wb_rf_wnum, exp_num[i], exp_pc[i]);
                    error_count++;
                end
                if (debug_wb_rf_wdata != exp_data[i]) begin
                    $display("Fail debug_wb_rf_wdata: got %h expected %h at pc %h",
                             debug_wb_rf_wdata, exp_data[i], exp_pc[i]);
                    error_count++;
                end
                checked++;
            end
        end
        done = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import la_core_pkg::*;

    logic        clk;
    logic        reset;
    logic        inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;
    logic        done;
    int          checked;
    int          error_count;
    logic [31:0] imem [1024];
    logic [31:0] dmem [256];
    logic [31:0] lfsr;

    mycpu_top uut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    trace_checker u_checker (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_we      (inst_sram_we),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .done              (done),
        .checked           (checked),
        .error_count       (error_count)
    );

    always #10 clk = ~clk;

    // Both memories answer one clock after they see the address.
    always @(posedge clk) begin
        if (inst_sram_we)
            imem[inst_sram_addr[11:2]] <= inst_sram_wdata;
        inst_sram_rdata <= imem[inst_sram_addr[11:2]];
        if (data_sram_we)
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        data_sram_rdata <= dmem[data_sram_addr[9:2]];
    end

    // Galois LFSR, one step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'b0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [4:0] pick_3r_op(input logic [2:0] sel);
        case (sel)
            3'd0:    return op5_add_w;
            3'd1:    return op5_sub_w;
            3'd2:    return op5_slt;
            3'd3:    return op5_sltu;
            3'd4:    return op5_nor;
            3'd5:    return op5_and;
            3'd6:    return op5_or;
            default: return op5_xor;
        endcase
    endfunction

    function automatic logic [31:0] random_inst();
        logic [2:0]  kind;
        logic [2:0]  sel;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [15:0] offs;
        kind = 3'(rand_bits(3));
        sel  = 3'(rand_bits(3));
        rd   = 5'(rand_bits(4));
        rj   = 5'(rand_bits(4));
        rk   = 5'(rand_bits(4));
        case (kind)
            3'd4: begin
                if (sel == 3'd0)
                    return {op6_arith, op4_shift, op2_shift, op5_slli_w, 5'(rand_bits(5)), rj, rd};
                else if (sel == 3'd1)
                    return {op6_arith, op4_shift, op2_shift, op5_srli_w, 5'(rand_bits(5)), rj, rd};
                else if (sel == 3'd2)
                    return {op6_arith, op4_shift, op2_shift, op5_srai_w, 5'(rand_bits(5)), rj, rd};
                else if (sel < 3'd6)
                    return {op6_arith, op4_addi_w, 12'(rand_bits(12)), rj, rd};
                else
                    return {op6_lu12i_w, 1'b0, 20'(rand_bits(20)), rd};
            end
            3'd5: return {op6_mem, op4_ld_w, 2'b0, 8'(rand_bits(8)), 2'b0, 5'd20, rd};
            3'd6: return {op6_mem, op4_st_w, 2'b0, 8'(rand_bits(8)), 2'b0, 5'd20, rd};
            3'd7: begin
                offs = 16'(rand_bits(2)) + 16'd1;   // Forward by 1 to 4 instructions.
                if (sel[1:0] == 2'd0)
                    return {op6_beq, offs, rj, rd};
                else if (sel[1:0] == 2'd1)
                    return {op6_bne, offs, rj, rd};
                else if (sel[1:0] == 2'd2)
                    return {op6_b, offs, 10'b0};
                else
                    return {op6_bl, offs, 10'b0};
            end
            default: return {op6_arith, op4_3r, op2_3r, pick_3r_op(sel), rk, rj, rd};
        endcase
    endfunction

    initial begin
        int idx;
        int cycles;
        clk             = 1'b0;
        reset           = 1'b1;
        inst_sram_rdata = 32'b0;
        data_sram_rdata = 32'b0;
        lfsr            = 32'h60e;
        for (int i = 0; i < 256; i++)
            dmem[i] = 32'b0;
        // Data base in r20, then random values in r2 to r15.
        imem[0] = {op6_lu12i_w, 1'b0, 20'h0, 5'd20};
        imem[1] = {op6_arith, op4_addi_w, 12'h100, 5'd20, 5'd20};
        idx = 2;
        for (int r = 2; r < 16; r++) begin
            imem[idx]     = {op6_lu12i_w, 1'b0, 20'(rand_bits(20)), r[4:0]};
            imem[idx + 1] = {op6_arith, op4_addi_w, 12'(rand_bits(12)), r[4:0], r[4:0]};
            idx = idx + 2;
        end
        // r21 points at word 33; the jirl adds 4 and skips word 33.
        imem[30] = {op6_lu12i_w, 1'b0, 20'h1c000, 5'd21};
        imem[31] = {op6_arith, op4_addi_w, 12'd132, 5'd21, 5'd21};
        imem[32] = {op6_jirl, 16'd1, 5'd21, 5'd1};
        imem[33] = {op6_arith, op4_addi_w, 12'd1, 5'd4, 5'd4};
        idx = 34;
        for (int i = 0; i < 200; i++) begin
            imem[idx] = random_inst();
            idx = idx + 1;
        end
        for (int i = 0; i < 5; i++)
            imem[idx + i] = {op6_b, 26'b0};   // Self loops end the program.
        for (int i = 0; i < 1024; i++)
            u_checker.prog[i] = imem[i];
        for (int i = 0; i < 5; i++)
            @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        while (!done && cycles < 50000) begin
            @(posedge clk);
            cycles++;
        end
        if (!done)
            $display("Timeout: the trace checker never finished");
        $display("Checked %0d register writes, %0d errors", checked, error_count);
        if (done && error_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/la_core_pkg.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/alu.sv
logic/mycpu_top.sv
verification/trace_checker.sv
verification/tb_top.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = tb_top
FILELIST = sources.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir
